/* rtl/datapath_macros.svh */
`ifndef DATAPATH_MACROS_SVH
`define DATAPATH_MACROS_SVH

// ############################################################
// Datapath sizes
// ############################################################

`define WORD_WIDTH 32
`define REG_COUNT  16

// ############################################################
// ALU operation codes as driven on operation
// ############################################################

`define ALU_ADD 5'd3
`define ALU_SUB 5'd4
`define ALU_AND 5'd5
`define ALU_OR  5'd6
`define ALU_SHR 5'd7
`define ALU_SHL 5'd9
`define ALU_NEG 5'd16
`define ALU_NOT 5'd17

`endif

/* rtl/isaPkg.sv */
`default_nettype none

`include "datapath_macros.svh"

package isaPkg;

        typedef logic [$clog2(`REG_COUNT)-1:0] regIndex;
        typedef logic [18:0]                   constField;

        typedef struct packed {
                logic [4:0]  opcode;
                regIndex     ra;
                regIndex     rb;
                regIndex     rc;
                logic [14:0] rest;
        } regFormat;

        // Immediate instructions such as ldi and addi carry C in the low bits
        typedef struct packed {
                logic [4:0] opcode;
                regIndex    ra;
                regIndex    rb;
                constField  c;
        } immFormat;

        // One IR word seen either as register form or as immediate form
        typedef union packed {
                regFormat regForm;
                immFormat immForm;
        } instrWord;

endpackage

`default_nettype wire

/* rtl/busSourceIf.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_macros.svh"

interface busSourceIf;

        logic [`REG_COUNT-1:0][`WORD_WIDTH-1:0] regWords;
        logic [`REG_COUNT-1:0]                  rOut;
        logic [`WORD_WIDTH-1:0]                 pcWord;
        logic [`WORD_WIDTH-1:0]                 mdrWord;
        logic [`WORD_WIDTH-1:0]                 zLowWord;
        logic [`WORD_WIDTH-1:0]                 zHighWord;
        logic [`WORD_WIDTH-1:0]                 cWord;
        logic                                   PCout;
        logic                                   MDRout;
        logic                                   Zlowout;
        logic                                   ZHighout;
        logic                                   Cout;
        logic [`WORD_WIDTH-1:0]                 busData;   // The one shared bus

        modport source (output regWords, rOut, pcWord, mdrWord, zLowWord, zHighWord, cWord);
        modport encoder (input regWords, rOut, pcWord, mdrWord, zLowWord, zHighWord, cWord,
                         input PCout, MDRout, Zlowout, ZHighout, Cout,
                         output busData);
        modport sink (input busData);

endinterface

`default_nettype wire

/* rtl/selectEncode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_macros.svh"

module selectEncode (
        input  isaPkg::instrWord       ir,
        input  logic                   GRA,
        input  logic                   GRB,
        input  logic                   GRC,
        input  logic                   Rin,
        input  logic                   Rout,
        input  logic                   BAout,
        output logic [`REG_COUNT-1:0]  rIn,
        busSourceIf.source             srcBus
);
        import isaPkg::*;

        localparam int ConstWidth = $bits(constField);

        regIndex               selField;
        logic                  anyGr;
        logic [`REG_COUNT-1:0] selOneHot;

        assign anyGr = GRA | GRB | GRC;

        always_comb begin
                selField = '0;
                if (GRA) begin
                        selField = ir.regForm.ra;
                end else if (GRB) begin
                        selField = ir.regForm.rb;
                end else if (GRC) begin
                        selField = ir.regForm.rc;
                end
        end

        // Decode the chosen field to a one-hot register select
        always_comb begin
                selOneHot = '0;
                selOneHot[selField] = anyGr;
        end

        assign rIn         = selOneHot & {`REG_COUNT{Rin}};
        assign srcBus.rOut = selOneHot & {`REG_COUNT{Rout | BAout}};   // BAout reads base register

        assign srcBus.cWord = {{(`WORD_WIDTH - ConstWidth){ir.immForm.c[ConstWidth-1]}},
                               ir.immForm.c};

        // The control unit names one register field per step
        always_comb begin
                assert ($onehot0({GRA, GRB, GRC}))
                else $error("selectEncode: more than one of GRA GRB GRC high");
        end

endmodule

`default_nettype wire

/* rtl/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_macros.svh"

module registerFile (
        input  logic                  Clock,
        input  logic                  arstN,
        input  logic [`REG_COUNT-1:0] rIn,
        input  logic                  BAout,
        busSourceIf.source            srcBus,
        busSourceIf.sink              sinkBus
);

        logic [`REG_COUNT-1:0][`WORD_WIDTH-1:0] regs;

        // ############################################################
        // General register storage
        // ############################################################

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        regs <= '0;
                end else begin
                        for (int i = 0; i < `REG_COUNT; i++) begin
                                if (rIn[i]) begin
                                        regs[i] <= sinkBus.busData;
                                end
                        end
                end
        end

        // ############################################################
        // Words offered to the bus
        // ############################################################

        always_comb begin
                for (int i = 0; i < `REG_COUNT; i++) begin
                        srcBus.regWords[i] = regs[i];
                end
                // Base-plus-constant addressing treats R0 as zero
                if (BAout) begin
                        srcBus.regWords[0] = '0;
                end
        end

endmodule

`default_nettype wire

/* rtl/aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_macros.svh"

module aluUnit (
        input  logic       Clock,
        input  logic       arstN,
        input  logic       Yin,
        input  logic       Zin,
        input  logic       IncPC,
        input  logic [4:0] operation,
        busSourceIf.source srcBus,
        busSourceIf.sink   sinkBus
);

        localparam int ShiftBits = $clog2(`WORD_WIDTH);

        logic [`WORD_WIDTH-1:0]   yReg;
        logic [2*`WORD_WIDTH-1:0] zReg;
        logic [2*`WORD_WIDTH-1:0] aluResult;
        logic [`WORD_WIDTH:0]     sumExt;   // One guard bit for carry or sign
        logic [`WORD_WIDTH-1:0]   busWord;

        assign busWord = sinkBus.busData;

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        yReg <= '0;
                end else if (Yin) begin
                        yReg <= busWord;
                end
        end

        // ############################################################
        // Operations with Y as the A operand and the bus as B
        // ############################################################

        always_comb begin
                sumExt    = '0;
                aluResult = '0;
                if (IncPC) begin
                        aluResult[`WORD_WIDTH-1:0] = busWord + 1;   // PC increment path
                end else begin
                        case (operation)
                                `ALU_ADD: begin
                                        sumExt = {yReg[`WORD_WIDTH-1], yReg} +
                                                 {busWord[`WORD_WIDTH-1], busWord};
                                        aluResult = {{(`WORD_WIDTH-1){sumExt[`WORD_WIDTH]}},
                                                     sumExt};
                                end
                                `ALU_SUB: begin
                                        sumExt = {yReg[`WORD_WIDTH-1], yReg} -
                                                 {busWord[`WORD_WIDTH-1], busWord};
                                        aluResult = {{(`WORD_WIDTH-1){sumExt[`WORD_WIDTH]}},
                                                     sumExt};
                                end
                                `ALU_AND: aluResult[`WORD_WIDTH-1:0] = yReg & busWord;
                                `ALU_OR:  aluResult[`WORD_WIDTH-1:0] = yReg | busWord;
                                `ALU_SHR: begin
                                        aluResult[`WORD_WIDTH-1:0] = yReg >> busWord[ShiftBits-1:0];
                                end
                                `ALU_SHL: begin
                                        aluResult[`WORD_WIDTH-1:0] = yReg << busWord[ShiftBits-1:0];
                                end
                                `ALU_NEG: aluResult[`WORD_WIDTH-1:0] = '0 - busWord;
                                `ALU_NOT: aluResult[`WORD_WIDTH-1:0] = ~busWord;
                                default:  aluResult = '0;
                        endcase
                end
        end

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        zReg <= '0;
                end else if (Zin) begin
                        zReg <= aluResult;
                end
        end

        assign srcBus.zLowWord  = zReg[`WORD_WIDTH-1:0];
        assign srcBus.zHighWord = zReg[2*`WORD_WIDTH-1:`WORD_WIDTH];

        // A Z load needs a known operation unless it is the PC increment
        zLoadDefined: assert property (@(posedge Clock) disable iff (!arstN)
                Zin |-> (IncPC || operation inside {`ALU_ADD, `ALU_SUB, `ALU_AND, `ALU_OR,
                                                     `ALU_SHR, `ALU_SHL, `ALU_NEG, `ALU_NOT}))
        else $error("aluUnit: Zin with undefined operation %0d", operation);

endmodule

`default_nettype wire

/* rtl/specialRegs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_macros.svh"

module specialRegs (
        input  logic                   Clock,
        input  logic                   arstN,
        input  logic                   PCin,
        input  logic                   IRin,
        input  logic                   MARin,
        input  logic                   MDRin,
        input  logic                   Read,
        input  logic [`WORD_WIDTH-1:0] memDataIn,
        output isaPkg::instrWord       ir,
        output logic [`WORD_WIDTH-1:0] marData,
        busSourceIf.source             srcBus,
        busSourceIf.sink               sinkBus
);
        import isaPkg::*;

        logic [`WORD_WIDTH-1:0] pcReg;
        instrWord               irReg;
        logic [`WORD_WIDTH-1:0] marReg;
        logic [`WORD_WIDTH-1:0] mdrReg;

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        pcReg  <= '0;
                        irReg  <= '0;
                        marReg <= '0;
                end else begin
                        if (PCin) pcReg <= sinkBus.busData;
                        if (IRin) irReg <= sinkBus.busData;
                        if (MARin) marReg <= sinkBus.busData;
                end
        end

        // Memory read data takes precedence over a bus load
        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        mdrReg <= '0;
                end else if (Read) begin
                        mdrReg <= memDataIn;
                end else if (MDRin) begin
                        mdrReg <= sinkBus.busData;
                end
        end

        assign ir             = irReg;
        assign marData        = marReg;
        assign srcBus.pcWord  = pcReg;
        assign srcBus.mdrWord = mdrReg;

        mdrSingleSource: assert property (@(posedge Clock) disable iff (!arstN)
                !(Read && MDRin))
        else $error("specialRegs: Read and MDRin high in the same step");

endmodule

`default_nettype wire

/* rtl/busEncoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_macros.svh"

module busEncoder (
        busSourceIf.encoder encBus
);

        // ############################################################
        // Priority select of the bus driver
        // ############################################################

        // Written lowest priority first so the later match wins
        always_comb begin
                encBus.busData = '0;   // Idle bus reads zero
                if (encBus.Cout) begin
                        encBus.busData = encBus.cWord;
                end
                if (encBus.MDRout) begin
                        encBus.busData = encBus.mdrWord;
                end
                if (encBus.ZHighout) begin
                        encBus.busData = encBus.zHighWord;
                end
                if (encBus.Zlowout) begin
                        encBus.busData = encBus.zLowWord;
                end
                if (encBus.PCout) begin
                        encBus.busData = encBus.pcWord;
                end
                for (int i = `REG_COUNT - 1; i >= 0; i--) begin
                        if (encBus.rOut[i]) begin
                                encBus.busData = encBus.regWords[i];
                        end
                end
        end

        // Only one block may drive the bus in a control step
        always_comb begin
                assert ($onehot0({encBus.rOut, encBus.PCout, encBus.Zlowout, encBus.ZHighout,
                                  encBus.MDRout, encBus.Cout}))
                else $error("busEncoder: more than one out-strobe high");
        end

endmodule

`default_nettype wire

/* rtl/datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_macros.svh"

module datapath (
        input  logic                   Clock,
        input  logic                   arstN,
        input  logic                   PCout,
        input  logic                   Zlowout,
        input  logic                   ZHighout,
        input  logic                   MDRout,
        input  logic                   Cout,
        input  logic                   MARin,
        input  logic                   Zin,
        input  logic                   PCin,
        input  logic                   MDRin,
        input  logic                   IRin,
        input  logic                   Yin,
        input  logic                   IncPC,
        input  logic                   Read,
        input  logic                   GRA,
        input  logic                   GRB,
        input  logic                   GRC,
        input  logic                   Rin,
        input  logic                   Rout,
        input  logic                   BAout,
        input  logic [4:0]             operation,
        input  logic [`WORD_WIDTH-1:0] memDataIn,
        output logic [`WORD_WIDTH-1:0] busData,
        output logic [`WORD_WIDTH-1:0] marData
);
        import isaPkg::*;

        instrWord              irWord;
        logic [`REG_COUNT-1:0] rIn;

        busSourceIf busIf ();

        // Out-strobes of the fixed sources go straight to the encoder
        assign busIf.PCout    = PCout;
        assign busIf.Zlowout  = Zlowout;
        assign busIf.ZHighout = ZHighout;
        assign busIf.MDRout   = MDRout;
        assign busIf.Cout     = Cout;
        assign busData        = busIf.busData;

        selectEncode selectEncode_inst (
                .ir(irWord), .GRA(GRA), .GRB(GRB), .GRC(GRC), .Rin(Rin), .Rout(Rout),
                .BAout(BAout), .rIn(rIn), .srcBus(busIf)
        );

        registerFile registerFile_inst (
                .Clock(Clock), .arstN(arstN), .rIn(rIn), .BAout(BAout),
                .srcBus(busIf), .sinkBus(busIf)
        );

        aluUnit aluUnit_inst (
                .Clock(Clock), .arstN(arstN), .Yin(Yin), .Zin(Zin), .IncPC(IncPC),
                .operation(operation), .srcBus(busIf), .sinkBus(busIf)
        );

        specialRegs specialRegs_inst (
                .Clock(Clock), .arstN(arstN), .PCin(PCin), .IRin(IRin), .MARin(MARin),
                .MDRin(MDRin), .Read(Read), .memDataIn(memDataIn), .ir(irWord),
                .marData(marData), .srcBus(busIf), .sinkBus(busIf)
        );

        busEncoder busEncoder_inst (
                .encBus(busIf)
        );

endmodule

`default_nettype wire

/* bench/datapathTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_macros.svh"

module datapathTb;

        localparam int ClockPeriod = 40;
        localparam int DriveDelay  = 2;
        localparam int ResetCycles = 3;
        localparam int FieldCount  = 6;   // Words per control step in the vector file
        localparam int MaxSteps    = 64;

        logic                   Clock;
        logic                   arstN;
        logic                   PCout, Zlowout, ZHighout, MDRout, Cout;
        logic                   MARin, Zin, PCin, MDRin, IRin, Yin;
        logic                   IncPC, Read, GRA, GRB, GRC, Rin, Rout, BAout;
        logic [4:0]             operation;
        logic [`WORD_WIDTH-1:0] memDataIn;
        logic [`WORD_WIDTH-1:0] busData;
        logic [`WORD_WIDTH-1:0] marData;

        logic [31:0] vectors [0:FieldCount*MaxSteps-1];
        int          stepCount;
        bit          vectorsLoaded = 1'b0;
        bit          testFailed;
        int          passCount;
        int          failCount;

        datapath datapath_inst (.*);

        initial begin
                Clock = 1'b0;
                forever #(ClockPeriod / 2) Clock = ~Clock;
        end

        // ############################################################
        // Helpers
        // ############################################################

        function automatic string testName(input int number);
                case (number)
                        1:       return "idle bus after reset";
                        2:       return "instruction fetch";
                        3:       return "load immediate";
                        4:       return "negative constant";
                        5:       return "ALU operations";
                        6:       return "idle bus after activity";
                        default: return "unknown test";
                endcase
        endfunction

        // Strobe word bit 18 is PCout and bit 0 is BAout
        task automatic driveStrobes(input logic [31:0] strobes, input logic [31:0] op,
                                    input logic [31:0] mem);
                {PCout, Zlowout, ZHighout, MDRout, Cout, MARin, Zin, PCin, MDRin, IRin, Yin,
                 IncPC, Read, GRA, GRB, GRC, Rin, Rout, BAout} = strobes[18:0];
                operation = op[4:0];
                memDataIn = mem;
        endtask

        task automatic checkStep(input int number, input int step,
                                 input logic [31:0] expBus, input logic [31:0] expMar);
                assert (busData === expBus)
                else begin
                        $display("ERROR %s step %0d: busData expected %h actual %h",
                                 testName(number), step, expBus, busData);
                        testFailed = 1'b1;
                end
                assert (marData === expMar)
                else begin
                        $display("ERROR %s step %0d: marData expected %h actual %h",
                                 testName(number), step, expMar, marData);
                        testFailed = 1'b1;
                end
        endtask

        task automatic reportTest(input int number);
                if (testFailed) begin
                        failCount++;
                        $display("FAIL %s", testName(number));
                end else begin
                        passCount++;
                        $display("PASS %s", testName(number));
                end
                testFailed = 1'b0;
        endtask

        // ############################################################
        // Vector replay
        // ############################################################

        initial begin : controlSteps
                int base;
                int number;
                int currentTest;
                arstN       = 1'b0;
                driveStrobes('0, '0, '0);
                testFailed  = 1'b0;
                passCount   = 0;
                failCount   = 0;
                currentTest = 0;
                $readmemh("bench/datapath_vectors.txt", vectors);
                stepCount = 0;
                while (stepCount < MaxSteps && vectors[stepCount*FieldCount+5] != 0) begin
                        stepCount++;   // A test number of zero ends the list
                end
                if (stepCount == 0) begin
                        $display("No control steps were read from the vector file");
                end
                vectorsLoaded = 1'b1;
                repeat (ResetCycles) @(posedge Clock);
                #DriveDelay;
                arstN = 1'b1;
                for (int step = 0; step < stepCount; step++) begin
                        base   = step * FieldCount;
                        number = vectors[base+5];
                        if (number != currentTest) begin
                                if (currentTest != 0) reportTest(currentTest);
                                currentTest = number;
                        end
                        driveStrobes(vectors[base], vectors[base+1], vectors[base+2]);
                        @(negedge Clock);   // Bus and MAR have settled by mid-cycle
                        checkStep(number, step, vectors[base+3], vectors[base+4]);
                        @(posedge Clock);
                        #DriveDelay;
                end
                if (currentTest != 0) reportTest(currentTest);
                $display("Tests passed: %0d, tests failed: %0d", passCount, failCount);
                if (failCount == 0 && passCount > 0) begin
                        $display("All tests passed");
                end else begin
                        $display("Some tests failed");
                end
                $finish;
        end

        initial begin : watchdog
                wait (vectorsLoaded);
                #((stepCount + 10) * ClockPeriod);
                $display("Run timed out before all control steps finished");
                $display("Some tests failed");
                $finish;
        end

endmodule

`default_nettype wire

/* bench/datapath_vectors.txt */
// strobes operation memDataIn busData marData test; test 0 ends the list
// strobes bits 18..0: PCout Zlowout ZHighout MDRout Cout MARin Zin PCin MDRin IRin Yin IncPC Read GRA GRB GRC Rin Rout BAout
00000 00 00000000 00000000 00000000 1
// Preset PC to 0x10, then fetch ldi R4, R0, 0x54
00040 00 00000010 00000000 00000000 2
08800 00 00000000 00000010 00000000 2
43080 00 00000000 00000010 00000000 2
20840 00 2A000054 00000011 00000010 2
08200 00 00000000 2A000054 00000010 2
40000 00 00000000 00000011 00000010 2
// ldi: Y gets zero through BAout, Z gets 0 + C, R4 written and read back
00111 00 00000000 00000000 00000010 3
05000 03 00000000 00000054 00000010 3
20024 00 00000000 00000054 00000010 3
00022 00 00000000 00000054 00000010 3
// addi R5, R4, -16 with a C field of 0x7FFF0
00040 00 32A7FFF0 00000000 00000010 4
08200 00 00000000 32A7FFF0 00000010 4
04000 00 00000000 FFFFFFF0 00000010 4
00112 00 00000000 00000054 00000010 4
05000 03 00000000 FFFFFFF0 00000010 4
20024 00 00000000 00000044 00000010 4
10000 00 00000000 00000000 00000010 4
00022 00 00000000 00000044 00000010 4
// Register form ra=1 rb=2 rc=3; R2 = F0F0A5A5 into Y, R3 = 3C3C0F08 on the bus
00040 00 00918000 00000000 00000010 5
08200 00 00000000 00918000 00000010 5
00040 00 F0F0A5A5 00000000 00000010 5
08014 00 00000000 F0F0A5A5 00000010 5
00040 00 3C3C0F08 00000000 00000010 5
0800C 00 00000000 3C3C0F08 00000010 5
00112 00 00000000 F0F0A5A5 00000010 5
0100A 05 00000000 3C3C0F08 00000010 5
20000 00 00000000 30300500 00000010 5
0100A 06 00000000 3C3C0F08 00000010 5
20000 00 00000000 FCFCAFAD 00000010 5
0100A 04 00000000 3C3C0F08 00000010 5
20000 00 00000000 B4B4969D 00000010 5
10000 00 00000000 FFFFFFFF 00000010 5
0100A 07 00000000 3C3C0F08 00000010 5
20000 00 00000000 00F0F0A5 00000010 5
0100A 09 00000000 3C3C0F08 00000010 5
20000 00 00000000 F0A5A500 00000010 5
0100A 10 00000000 3C3C0F08 00000010 5
20000 00 00000000 C3C3F0F8 00000010 5
0100A 11 00000000 3C3C0F08 00000010 5
20000 00 00000000 C3C3F0F7 00000010 5
00000 00 00000000 00000000 00000010 6
00000 00 00000000 00000000 00000000 0

/* sources.f */
+incdir+rtl
rtl/isaPkg.sv
rtl/busSourceIf.sv
rtl/selectEncode.sv
rtl/registerFile.sv
rtl/aluUnit.sv
rtl/specialRegs.sv
rtl/busEncoder.sv
rtl/datapath.sv
bench/datapathTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= datapathTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
PASS_TEXT ?= All tests passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
